//--- vlog.f
src/dl_pkg.sv
src/dl_item_if.sv
src/dl_spi_rx.sv
src/dl_item_fifo.sv
src/dl_ioctl_writer.sv
src/dl_rom_loader.sv
verif/dl_rom_loader_asserts.sv
verif/tb_rom_loader.sv

//--- run.sh
#!/bin/sh
# build the ROM loader testbench with Verilator, run it and look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_rom_loader -Mdir obj_dir &&
./obj_dir/Vtb_rom_loader | tee sim.log ||
echo "build or simulation did not complete"
grep -q "Everything OK" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verif/tb_rom_loader.sv
// ROM loader testbench
// sends SPI download frames with random pacing and payload, models the
// expected ioctl writes and checks order, addresses, index and flags
`timescale 1ns/1ps
`default_nettype none

module tb_rom_loader import dl_pkg::*; ();

   localparam logic [31:0] SEED    = 32'hc63500e3;
   localparam int          TIMEOUT = 4000;

   typedef logic [7:0] byte_q_t[$];

   logic              clk = 1'b0;
   logic              rst_n;
   logic              spi_sck;
   logic              spi_ss2;
   logic              spi_di;
   logic              ioctl_wait = 1'b0;
   logic [ADDR_W-1:0] ioctl_addr;
   logic [7:0]        ioctl_data;
   logic              ioctl_wr;
   logic [7:0]        ioctl_index;
   logic              downloading;
   logic              overflow;

   logic [31:0]       lfsr = SEED;
   logic [31:0]       wait_lfsr = SEED;
   logic              wait_random = 1'b0;
   logic              wait_hold = 1'b0;

   // model and captured writes
   logic [7:0]        exp_data[$];
   logic [7:0]        exp_index;
   logic [ADDR_W-1:0] got_addr[$];
   logic [7:0]        got_data[$];
   int                wr_in_wait;

   string             cur_test;
   int                test_errs;
   int                tests_run;
   int                tests_failed;

   dl_rom_loader DUT (
      .clk_rom_i     ( clk         ),
      .rst_n_i       ( rst_n       ),
      .spi_sck_i     ( spi_sck     ),
      .spi_ss2_i     ( spi_ss2     ),
      .spi_di_i      ( spi_di      ),
      .ioctl_wait_i  ( ioctl_wait  ),
      .ioctl_addr_o  ( ioctl_addr  ),
      .ioctl_data_o  ( ioctl_data  ),
      .ioctl_wr_o    ( ioctl_wr    ),
      .ioctl_index_o ( ioctl_index ),
      .downloading_o ( downloading ),
      .overflow_o    ( overflow    )
   );

   always #20 clk = ~clk;

   // memory busy line, either held or random per cycle
   always @(posedge clk) begin
      if (wait_random) begin
         wait_lfsr = lfsr_next(wait_lfsr);
         ioctl_wait <= wait_lfsr[0];
      end else begin
         ioctl_wait <= wait_hold;
      end
   end

   // capture every write strobe
   always @(posedge clk) begin
      if (rst_n && ioctl_wr) begin
         got_addr.push_back(ioctl_addr);
         got_data.push_back(ioctl_data);
         if (ioctl_wait) begin
            wr_in_wait++;
         end
      end
   end

   // Galois LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic int half_period();
      return 4 + int'(rand_bits(2));
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("FAILED %s: %s expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic expect_true(input logic cond, input string msg);
      assert (cond === 1'b1) else begin
         $display("ERROR %s: %s", cur_test, msg);
         test_errs++;
      end
   endtask

   task automatic wait_downloading(input logic level);
      int n;
      n = 0;
      while (downloading !== level && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      expect_true(downloading === level,
                  $sformatf("timed out waiting for downloading_o to become %0b", level));
   endtask

   task automatic poll_overflow();
      int n;
      n = 0;
      while (overflow !== 1'b1 && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      expect_true(overflow === 1'b1, "timed out waiting for overflow_o to rise");
   endtask

   // mode 0, MSB first, random half period
   task automatic send_byte(input logic [7:0] b);
      for (int i = 7; i >= 0; i--) begin
         spi_di <= b[i];
         idle_cycles(half_period());
         spi_sck <= 1'b1;
         idle_cycles(half_period());
         spi_sck <= 1'b0;
      end
   endtask

   task automatic send_frame(input byte_q_t frame);
      spi_ss2 <= 1'b0;
      idle_cycles(half_period());
      foreach (frame[i]) begin
         send_byte(frame[i]);
      end
      idle_cycles(half_period());
      spi_ss2 <= 1'b1;
      idle_cycles(8);
   endtask

   task automatic send_start(input logic [7:0] idx);
      byte_q_t frame;
      frame.push_back(CMD_START);
      frame.push_back(idx);
      exp_index = idx;
      send_frame(frame);
   endtask

   task automatic send_end();
      byte_q_t frame;
      frame.push_back(CMD_END);
      send_frame(frame);
   endtask

   task automatic send_data(input int n);
      byte_q_t    frame;
      logic [7:0] b;
      frame.push_back(CMD_DATA);
      for (int i = 0; i < n; i++) begin
         b = 8'(rand_bits(8));
         frame.push_back(b);
         exp_data.push_back(b);
      end
      send_frame(frame);
   endtask

   // writes land at addresses counting from 0
   task automatic compare_writes(input int n);
      for (int i = 0; i < n; i++) begin
         if (i < got_data.size() && i < exp_data.size()) begin
            check_value($sformatf("address of write %0d", i), 32'(i), 32'(got_addr[i]));
            check_value($sformatf("data of write %0d", i), 32'(exp_data[i]),
                        32'(got_data[i]));
         end
      end
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      test_errs = 0;
      got_addr.delete();
      got_data.delete();
      exp_data.delete();
      wr_in_wait = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("test %-14s passed", cur_test);
      end else begin
         tests_failed++;
         $display("test %-14s failed with %0d errors", cur_test, test_errs);
      end
   endtask

   task automatic download(input int n);
      send_start(8'(rand_bits(8)));
      wait_downloading(1'b1);
      check_value("ioctl_index_o", 32'(exp_index), 32'(ioctl_index));
      send_data(n);
      send_end();
      wait_downloading(1'b0);
      check_value("write count", 32'(n), 32'(got_data.size()));
      compare_writes(n);
   endtask

   task automatic after_reset();
      begin_test("reset");
      check_value("ioctl_wr_o", 0, 32'(ioctl_wr));
      check_value("downloading_o", 0, 32'(downloading));
      check_value("overflow_o", 0, 32'(overflow));
      finish_test();
   endtask

   task automatic basic_download();
      begin_test("basic");
      download(40);
      check_value("downloading_o after END", 0, 32'(downloading));
      finish_test();
   endtask

   task automatic back_pressure();
      begin_test("back_pressure");
      wait_random <= 1'b1;
      download(30);
      wait_random <= 1'b0;
      idle_cycles(2);
      check_value("overflow_o", 0, 32'(overflow));
      check_value("writes during wait", 0, 32'(wr_in_wait));
      finish_test();
   endtask

   task automatic fifo_overflow();
      begin_test("overflow");
      send_start(8'(rand_bits(8)));
      wait_downloading(1'b1);
      wait_hold <= 1'b1;
      send_data(14);
      poll_overflow();
      wait_hold <= 1'b0;
      send_end();
      wait_downloading(1'b0);
      expect_true(got_data.size() >= FIFO_DEPTH,
                  "fewer bytes written than the FIFO holds after an overflow");
      compare_writes(FIFO_DEPTH);
      finish_test();
   endtask

   task automatic unknown_command();
      byte_q_t           frame;
      logic [7:0]        cmd;
      logic [ADDR_W-1:0] addr_before;
      logic [7:0]        idx_before;
      begin_test("unknown_cmd");
      // open a download so that stray data items would show up as writes
      send_start(8'(rand_bits(8)));
      wait_downloading(1'b1);
      cmd = 8'(rand_bits(8));
      if (cmd inside {CMD_START, CMD_END, CMD_DATA}) begin
         cmd = cmd ^ 8'h80;
      end
      addr_before = ioctl_addr;
      idx_before = ioctl_index;
      frame.push_back(cmd);
      for (int i = 0; i < 6; i++) begin
         frame.push_back(8'(rand_bits(8)));
      end
      send_frame(frame);
      // nothing should happen, give the pipeline time to prove it
      idle_cycles(200);
      check_value("write count", 0, 32'(got_data.size()));
      check_value("ioctl_addr_o", 32'(addr_before), 32'(ioctl_addr));
      check_value("ioctl_index_o", 32'(idx_before), 32'(ioctl_index));
      check_value("downloading_o", 1, 32'(downloading));
      send_end();
      wait_downloading(1'b0);
      finish_test();
   endtask

   task automatic second_download();
      begin_test("second");
      // flag left over from the overflow run
      check_value("overflow_o before START", 1, 32'(overflow));
      send_start(8'(rand_bits(8)));
      wait_downloading(1'b1);
      check_value("overflow_o after START", 0, 32'(overflow));
      check_value("ioctl_index_o", 32'(exp_index), 32'(ioctl_index));
      send_data(24);
      send_end();
      wait_downloading(1'b0);
      check_value("write count", 24, 32'(got_data.size()));
      compare_writes(24);
      finish_test();
   endtask

   initial begin
      rst_n = 1'b0;
      spi_sck = 1'b0;
      spi_ss2 = 1'b1;
      spi_di = 1'b0;
      tests_run = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      idle_cycles(2);

      after_reset();
      basic_download();
      back_pressure();
      unknown_command();
      fifo_overflow();
      second_download();

      $display("tests run %0d, passed %0d, failed %0d",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/dl_rom_loader_asserts.sv
// ROM loader protocol checks
// four-phase rules on both item channels and the ioctl write strobe rules
`timescale 1ns/1ps
`default_nettype none

module dl_rom_loader_asserts import dl_pkg::*; (
   input logic       clk_rom_i,
   input logic       rst_n_i,
   input logic       buf_req_i,
   input logic       buf_ack_i,
   input dl_kind_t   buf_kind_i,
   input logic [7:0] buf_data_i,
   input logic       wr_req_i,
   input logic       wr_ack_i,
   input dl_kind_t   wr_kind_i,
   input logic [7:0] wr_data_i,
   input logic       ioctl_wr_i,
   input logic       ioctl_wait_i,
   input logic       downloading_i
);

   // req holds until the item is acknowledged
   a_buf_req_hold: assert property (@(posedge clk_rom_i) disable iff (!rst_n_i)
      buf_req_i && !buf_ack_i |=> buf_req_i)
      else $error("to_buf req dropped before ack");

   a_wr_req_hold: assert property (@(posedge clk_rom_i) disable iff (!rst_n_i)
      wr_req_i && !wr_ack_i |=> wr_req_i)
      else $error("to_wr req dropped before ack");

   // payload frozen while the item waits for ack
   a_buf_stable: assert property (@(posedge clk_rom_i) disable iff (!rst_n_i)
      buf_req_i && !buf_ack_i |=> $stable(buf_kind_i) && $stable(buf_data_i))
      else $error("to_buf kind or data changed before ack");

   a_wr_stable: assert property (@(posedge clk_rom_i) disable iff (!rst_n_i)
      wr_req_i && !wr_ack_i |=> $stable(wr_kind_i) && $stable(wr_data_i))
      else $error("to_wr kind or data changed before ack");

   // write strobe rules
   a_wr_one_cycle: assert property (@(posedge clk_rom_i) disable iff (!rst_n_i)
      ioctl_wr_i |=> !ioctl_wr_i)
      else $error("ioctl_wr_o high for more than one cycle");

   a_wr_no_wait: assert property (@(posedge clk_rom_i) disable iff (!rst_n_i)
      ioctl_wr_i |-> !ioctl_wait_i)
      else $error("ioctl_wr_o while ioctl_wait_i is high");

   a_wr_downloading: assert property (@(posedge clk_rom_i) disable iff (!rst_n_i)
      ioctl_wr_i |-> downloading_i)
      else $error("ioctl_wr_o outside a download");

endmodule

bind dl_rom_loader dl_rom_loader_asserts u_asserts (
   .clk_rom_i     ( clk_rom_i     ),
   .rst_n_i       ( rst_n_i       ),
   .buf_req_i     ( to_buf.req    ),
   .buf_ack_i     ( to_buf.ack    ),
   .buf_kind_i    ( to_buf.kind   ),
   .buf_data_i    ( to_buf.data   ),
   .wr_req_i      ( to_wr.req     ),
   .wr_ack_i      ( to_wr.ack     ),
   .wr_kind_i     ( to_wr.kind    ),
   .wr_data_i     ( to_wr.data    ),
   .ioctl_wr_i    ( ioctl_wr_o    ),
   .ioctl_wait_i  ( ioctl_wait_i  ),
   .downloading_i ( downloading_o )
);

`default_nettype wire

//--- src/dl_rom_loader.sv
// ROM loader top level
// SPI download channel to ioctl byte writes: receiver, item buffer
// and writer linked by two four-phase item channels
`timescale 1ns/1ps
`default_nettype none

module dl_rom_loader import dl_pkg::*; (
   input  logic              clk_rom_i,
   input  logic              rst_n_i,
   // SPI data channel from the I/O controller
   input  logic              spi_sck_i,
   input  logic              spi_ss2_i,
   input  logic              spi_di_i,
   // core ROM side
   input  logic              ioctl_wait_i,
   output logic [ADDR_W-1:0] ioctl_addr_o,
   output logic [7:0]        ioctl_data_o,
   output logic              ioctl_wr_o,
   output logic [7:0]        ioctl_index_o,
   output logic              downloading_o,
   output logic              overflow_o
);

   dl_item_if to_buf ();
   dl_item_if to_wr ();

   dl_spi_rx u_spi_rx (
      .clk_rom_i  ( clk_rom_i  ),
      .rst_n_i    ( rst_n_i    ),
      .spi_sck_i  ( spi_sck_i  ),
      .spi_ss2_i  ( spi_ss2_i  ),
      .spi_di_i   ( spi_di_i   ),
      .overflow_o ( overflow_o ),
      .item       ( to_buf     )
   );

   dl_item_fifo u_item_fifo (
      .clk_rom_i  ( clk_rom_i  ),
      .rst_n_i    ( rst_n_i    ),
      .in         ( to_buf     ),
      .out        ( to_wr      )
   );

   dl_ioctl_writer u_ioctl_writer (
      .clk_rom_i     ( clk_rom_i     ),
      .rst_n_i       ( rst_n_i       ),
      .item          ( to_wr         ),
      .ioctl_wait_i  ( ioctl_wait_i  ),
      .ioctl_addr_o  ( ioctl_addr_o  ),
      .ioctl_data_o  ( ioctl_data_o  ),
      .ioctl_wr_o    ( ioctl_wr_o    ),
      .ioctl_index_o ( ioctl_index_o ),
      .downloading_o ( downloading_o )
   );

endmodule

`default_nettype wire

//--- src/dl_ioctl_writer.sv
// ioctl write generator
// applies download items: START sets index and clears the address,
// DATA writes one byte and advances the address, END stops the download
`timescale 1ns/1ps
`default_nettype none

module dl_ioctl_writer import dl_pkg::*; (
   input  logic              clk_rom_i,
   input  logic              rst_n_i,
   dl_item_if.receiver       item,
   input  logic              ioctl_wait_i,
   output logic [ADDR_W-1:0] ioctl_addr_o,
   output logic [7:0]        ioctl_data_o,
   output logic              ioctl_wr_o,
   output logic [7:0]        ioctl_index_o,
   output logic              downloading_o
);

   logic [1:0] state;
   dl_kind_t   kind_q;
   logic       take;
   logic       act_done;

   assign take = (state == WR_IDLE) && item.req;

   // data outside a download is consumed without a write
   assign ioctl_wr_o = (state == WR_ACT) && (kind_q == KIND_DATA) &&
                       downloading_o && !ioctl_wait_i;

   // a data byte waits here while the memory is busy
   assign act_done = (state == WR_ACT) &&
                     ((kind_q != KIND_DATA) || !downloading_o || !ioctl_wait_i);

   always_ff @(posedge clk_rom_i) begin
      if (!rst_n_i) begin
         state         <= WR_IDLE;
         item.ack      <= 1'b0;
         ioctl_addr_o  <= '0;
         downloading_o <= 1'b0;
      end else begin
         case (state)
            WR_IDLE: begin
               if (take) begin
                  state <= WR_ACT;
               end
            end
            WR_ACT: begin
               if (act_done) begin
                  item.ack <= 1'b1;
                  state    <= WR_ACK;
                  case (kind_q)
                     KIND_START: begin
                        ioctl_addr_o  <= '0;
                        downloading_o <= 1'b1;
                     end
                     KIND_END: downloading_o <= 1'b0;
                     default: begin
                        if (ioctl_wr_o) begin
                           ioctl_addr_o <= ioctl_addr_o + 1'b1;
                        end
                     end
                  endcase
               end
            end
            WR_ACK: begin
               if (!item.req) begin
                  item.ack <= 1'b0;
                  state    <= WR_REL;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   // item payload, stable until ack rises
   always_ff @(posedge clk_rom_i) begin
      if (take) begin
         kind_q <= item.kind;
         if (item.kind == KIND_DATA) begin
            ioctl_data_o <= item.data;
         end
      end
      if ((state == WR_ACT) && (kind_q == KIND_START)) begin
         ioctl_index_o <= item.data;
      end
   end

endmodule

`default_nettype wire

//--- src/dl_item_fifo.sv
// Download item buffer
// circular buffer of FIFO_DEPTH items between the SPI receiver and the
// ioctl writer, four-phase handshake on both sides
`timescale 1ns/1ps
`default_nettype none

module dl_item_fifo import dl_pkg::*; (
   input  logic        clk_rom_i,
   input  logic        rst_n_i,
   dl_item_if.receiver in,
   dl_item_if.sender   out
);

   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
   logic [$clog2(FIFO_DEPTH):0]   count;
   dl_kind_t                      kind_mem [FIFO_DEPTH];
   logic [7:0]                    data_mem [FIFO_DEPTH];
   logic                          full;
   logic                          push;
   logic                          pop;
   logic                          load;

   assign full = (int'(count) == FIFO_DEPTH);
   // new input item, taken only with room left
   assign push = in.req && !in.ack && !full;
   // output item acknowledged by the writer
   assign pop  = out.req && out.ack;
   // present the next item once the last handshake is over
   assign load = !out.req && !out.ack && (count != '0);

   always_ff @(posedge clk_rom_i) begin
      if (!rst_n_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         in.ack  <= 1'b0;
         out.req <= 1'b0;
      end else begin
         // input side
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
            in.ack <= 1'b1;
         end else if (in.ack && !in.req) begin
            in.ack <= 1'b0;
         end

         // output side, pointers wrap since depth is a power of two
         if (pop) begin
            rd_ptr  <= rd_ptr + 1'b1;
            out.req <= 1'b0;
         end else if (load) begin
            out.req <= 1'b1;
         end

         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_rom_i) begin
      if (push) begin
         kind_mem[wr_ptr] <= in.kind;
         data_mem[wr_ptr] <= in.data;
      end
   end

   always_ff @(posedge clk_rom_i) begin
      if (load) begin
         out.kind <= kind_mem[rd_ptr];
         out.data <= data_mem[rd_ptr];
      end
   end

endmodule

`default_nettype wire

//--- src/dl_spi_rx.sv
// SPI download receiver
// oversamples the data channel (SS2, SDI, SCK) in the ROM clock domain,
// assembles bytes MSB first and turns the frame commands into items
`timescale 1ns/1ps
`default_nettype none

module dl_spi_rx import dl_pkg::*; (
   input  logic      clk_rom_i,
   input  logic      rst_n_i,
   input  logic      spi_sck_i,
   input  logic      spi_ss2_i,
   input  logic      spi_di_i,
   output logic      overflow_o,
   dl_item_if.sender item
);

   logic [1:0] sck_sync;
   logic [1:0] ss2_sync;
   logic [1:0] di_sync;
   logic       sck_last;
   logic       sck_rise;
   logic [2:0] bit_cnt;
   logic [6:0] shift_q;
   logic [7:0] new_byte;
   logic       byte_done;
   logic       cmd_seen;
   logic       start_mode;
   logic       data_mode;
   logic       emit;
   dl_kind_t   emit_kind;
   logic       busy;

   // two flop synchronizers, sck_last only for edge detection
   always_ff @(posedge clk_rom_i) begin
      if (!rst_n_i) begin
         sck_sync <= 2'b00;
         ss2_sync <= 2'b11;
         di_sync  <= 2'b00;
         sck_last <= 1'b0;
      end else begin
         sck_sync <= {sck_sync[0], spi_sck_i};
         ss2_sync <= {ss2_sync[0], spi_ss2_i};
         di_sync  <= {di_sync[0], spi_di_i};
         sck_last <= sck_sync[1];
      end
   end

   // mode 0, sample on rising sck inside the frame
   assign sck_rise  = sck_sync[1] & ~sck_last & ~ss2_sync[1];
   assign byte_done = sck_rise && (bit_cnt == 3'd7);
   assign new_byte  = {shift_q, di_sync[1]};

   always_ff @(posedge clk_rom_i) begin
      if (sck_rise) begin
         shift_q <= new_byte[6:0];
      end
   end

   // frame decoding, cleared whenever slave select is high
   always_ff @(posedge clk_rom_i) begin
      if (!rst_n_i) begin
         bit_cnt    <= 3'd0;
         cmd_seen   <= 1'b0;
         start_mode <= 1'b0;
         data_mode  <= 1'b0;
      end else if (ss2_sync[1]) begin
         bit_cnt    <= 3'd0;
         cmd_seen   <= 1'b0;
         start_mode <= 1'b0;
         data_mode  <= 1'b0;
      end else if (sck_rise) begin
         bit_cnt <= bit_cnt + 3'd1;
         if (byte_done) begin
            if (!cmd_seen) begin
               cmd_seen   <= 1'b1;
               start_mode <= (new_byte == CMD_START);
               data_mode  <= (new_byte == CMD_DATA);
            end else begin
               // only one index byte after START
               start_mode <= 1'b0;
            end
         end
      end
   end

   // which completed byte becomes an item
   always_comb begin
      emit      = 1'b0;
      emit_kind = KIND_DATA;
      if (byte_done) begin
         if (!cmd_seen) begin
            if (new_byte == CMD_END) begin
               emit      = 1'b1;
               emit_kind = KIND_END;
            end
         end else if (start_mode) begin
            emit      = 1'b1;
            emit_kind = KIND_START;
         end else if (data_mode) begin
            emit      = 1'b1;
            emit_kind = KIND_DATA;
         end
      end
   end

   // previous handshake not finished yet
   assign busy = item.req | item.ack;

   always_ff @(posedge clk_rom_i) begin
      if (!rst_n_i) begin
         item.req   <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         if (item.req && item.ack) begin
            item.req <= 1'b0;
         end
         if (emit) begin
            if (busy) begin
               overflow_o <= 1'b1;
            end else begin
               item.req <= 1'b1;
               // a new download starts with a clean flag
               if (emit_kind == KIND_START) begin
                  overflow_o <= 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge clk_rom_i) begin
      if (emit && !busy) begin
         item.kind <= emit_kind;
         item.data <= new_byte;
      end
   end

endmodule

`default_nettype wire

//--- src/dl_item_if.sv
// Download item channel
// four-phase req/ack link carrying one byte and its kind
`timescale 1ns/1ps
`default_nettype none

interface dl_item_if import dl_pkg::*; ();

   logic       req;
   logic       ack;
   // kind and data are held stable while req is high
   dl_kind_t   kind;
   logic [7:0] data;

   modport sender (
      output req,
      output kind,
      output data,
      input  ack
   );

   modport receiver (
      input  req,
      input  kind,
      input  data,
      output ack
   );

endinterface

`default_nettype wire

//--- src/dl_pkg.sv
// ROM download shared definitions
// command codes of the SPI data channel, item kinds, buffer depth,
// address width and the ioctl writer state codes
`default_nettype none

package dl_pkg;

   // frame command bytes
   localparam logic [7:0] CMD_START = 8'h54;
   localparam logic [7:0] CMD_END   = 8'h55;
   localparam logic [7:0] CMD_DATA  = 8'h56;

   // how the consumer treats the byte of an item
   typedef enum logic [1:0] {
      KIND_START,
      KIND_DATA,
      KIND_END
   } dl_kind_t;

   // item entries in the buffer, a power of two
   localparam int FIFO_DEPTH = 8;

   // width of the ROM byte address
   localparam int ADDR_W = 25;

   // ioctl writer FSM
   localparam logic [1:0] WR_IDLE = 2'd0;
   localparam logic [1:0] WR_ACT  = 2'd1;
   localparam logic [1:0] WR_ACK  = 2'd2;
   localparam logic [1:0] WR_REL  = 2'd3;

endpackage

`default_nettype wire
